// ==== ps2_host.f ====
+incdir+sim
rtl/ps2_pkg.sv
rtl/ps2_rx.sv
rtl/ps2_key_tracker.sv
rtl/ps2_event_fifo.sv
rtl/ps2_axil_regs.sv
rtl/ps2_host.sv
sim/ps2_host_tb.sv

// ==== Makefile ====
# Verilator flow for the two-port PS/2 host controller
VERILATOR  ?= verilator
TOP        := ps2_host_tb
FILELIST   := ps2_host.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The grep decides the exit status, the tee keeps the output visible
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/ps2_host_tb_tasks.svh ====
// PS/2 frame source and AXI4-Lite master tasks for the PS/2 host testbench
// Included inside the testbench module, uses its signals and counters
// All inputs change on the falling system clock edge
`ifndef PS2_HOST_TB_TASKS_SVH
`define PS2_HOST_TB_TASKS_SVH

// One 11-bit device-to-host frame, the other port stays idle
task automatic send_frame(input bit aux, input logic [7:0] value, input bit bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0}; // Stop, parity, data, start
    for (int i = 0; i < 11; i++) begin
        aux_dat = aux ? frame[i] : 1'b1;   // Data moves while the clock is high
        kbd_dat = aux ? 1'b1 : frame[i];
        repeat (HALF_PERIOD) @(negedge clk);
        aux_clk = !aux;                    // Falling edge strobes the bit
        kbd_clk = aux;
        repeat (HALF_PERIOD) @(negedge clk);
        aux_clk = 1'b1;
        kbd_clk = 1'b1;
    end
    aux_dat = 1'b1;
    kbd_dat = 1'b1;
    repeat (HALF_PERIOD) @(negedge clk);   // Idle gap between frames
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int delay;
    delay = $urandom_range(3, 0);          // rready back-pressure
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    while (!s_axil_arready)
        @(negedge clk);
    @(negedge clk);                        // Address taken on the edge before
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid)
        @(negedge clk);
    repeat (delay) @(negedge clk);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    s_axil_rready = 1'b1;
    @(negedge clk);
    s_axil_rready = 1'b0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
    int delay;
    delay = $urandom_range(3, 0);          // bready back-pressure
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_wstrb   = 4'hF;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    while (!s_axil_awready)                // awready and wready rise together
        @(negedge clk);
    checks++;
    assert (s_axil_wready) else begin
        $display("FAILED at %0t: wready low while awready is high", $time);
        errors++;
    end
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid)
        @(negedge clk);
    repeat (delay) @(negedge clk);
    resp = s_axil_bresp;
    s_axil_bready = 1'b1;
    @(negedge clk);
    s_axil_bready = 1'b0;
endtask

`endif

// ==== sim/ps2_host_tb.sv ====
// Testbench for the two-port PS/2 host, receive direction only
// Both FIFO depths are 4 here, the overflow test relies on that
// PS/2 half-period is 30 system cycles, far slower than the filter
`timescale 1ns/1ps

module ps2_host_tb
    import ps2_pkg::*;
();

    localparam int HALF_PERIOD    = 30;
    localparam int POLL_LIMIT     = 50;
    localparam int TIMEOUT_CYCLES = 20 * 11 * 60 + 2000; // Frames x bits x cycles per bit
    localparam logic [31:0] VALID = 32'h1 << EVENT_VALID_BIT;
    localparam logic [7:0] A_STATUS  = {4'h0, REG_STATUS};
    localparam logic [7:0] A_KBD     = {4'h0, REG_KBD_EVENT};
    localparam logic [7:0] A_AUX     = {4'h0, REG_AUX_DATA};
    localparam logic [7:0] A_CONTROL = {4'h0, REG_CONTROL};

    logic clk, reset;
    logic kbd_clk, kbd_dat, aux_clk, aux_dat;
    logic [7:0]  s_axil_awaddr, s_axil_araddr;
    logic [31:0] s_axil_wdata, s_axil_rdata;
    logic [3:0]  s_axil_wstrb;
    logic [1:0]  s_axil_bresp, s_axil_rresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic s_axil_rvalid, s_axil_rready;
    int   errors = 0;
    int   checks = 0;
    int   tests  = 0;
    int   cycles = 0;

    `include "ps2_host_tb_tasks.svh"

    ps2_host #(.FILTER_LEN(8), .KBD_DEPTH(4), .AUX_DEPTH(4)) i_dut (.*);

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock and timeout
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Expected data word for a keyboard event
    function automatic logic [31:0] event_word(input logic rel, input logic ext,
                                               input logic [7:0] code);
        return VALID | {22'h0, rel, ext, code};
    endfunction

    task automatic check_read(input string what, input logic [31:0] got,
                              input logic [1:0] got_resp, input logic [31:0] exp,
                              input logic [1:0] exp_resp);
        checks++;
        assert (got == exp && got_resp == exp_resp) else begin
            $display("FAILED at %0t: %s gave %08h resp %0d, expected %08h resp %0d",
                     $time, what, got, got_resp, exp, exp_resp);
            errors++;
        end
    endtask

    // Polls STATUS until one bit rises
    task automatic wait_status(input int bit_pos);
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[bit_pos] && polls < POLL_LIMIT) begin
            read_reg(A_STATUS, status, resp);
            polls++;
        end
        if (!status[bit_pos]) begin
            $display("Status bit %0d never came up within %0d polls", bit_pos, POLL_LIMIT);
            errors++;
        end
    endtask

    task automatic print_result(input string name, input int mark);
        tests++;
        $display("Test %0d %s finished with %0d errors", tests, name, errors - mark);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] word;
        logic [1:0]  resp;
        logic [7:0]  sent [5];
        int          mark;
        void'($urandom(2));
        reset = 1'b0;
        kbd_clk = 1'b1;                     // Idle PS/2 lines are high
        kbd_dat = 1'b1;
        aux_clk = 1'b1;
        aux_dat = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b1;

        mark = errors;                      // Plain make code
        send_frame(1'b0, 8'h1C, 1'b0);
        wait_status(STATUS_KBD_AVAIL);
        read_reg(A_KBD, word, resp);
        check_read("make code event", word, resp, event_word(1'b0, 1'b0, 8'h1C), RESP_OKAY);
        read_reg(A_KBD, word, resp);
        check_read("empty keyboard read", word, resp, 32'h0, RESP_OKAY);
        print_result("make code", mark);

        mark = errors;                      // Extended break folds into one event
        send_frame(1'b0, 8'hE0, 1'b0);
        send_frame(1'b0, 8'hF0, 1'b0);
        send_frame(1'b0, 8'h75, 1'b0);
        wait_status(STATUS_KBD_AVAIL);
        read_reg(A_KBD, word, resp);
        check_read("prefixed event", word, resp, event_word(1'b1, 1'b1, 8'h75), RESP_OKAY);
        read_reg(A_KBD, word, resp);
        check_read("read after prefixed event", word, resp, 32'h0, RESP_OKAY);
        print_result("prefixes", mark);

        mark = errors;
        send_frame(1'b0, 8'h2A, 1'b1);      // Bad parity
        wait_status(STATUS_KBD_ERR);
        read_reg(A_STATUS, word, resp);
        check_read("status after parity error", word, resp, 32'h1 << STATUS_KBD_ERR,
                   RESP_OKAY);
        write_reg(A_CONTROL, 32'h1 << STATUS_KBD_ERR, resp);
        check_read("clear of keyboard error", 32'h0, resp, 32'h0, RESP_OKAY);
        read_reg(A_STATUS, word, resp);
        check_read("status after clear", word, resp, 32'h0, RESP_OKAY);
        print_result("parity error", mark);

        mark = errors;
        for (int i = 0; i < 3; i++) begin
            sent[i] = 8'($urandom);
            send_frame(1'b1, sent[i], 1'b0);
        end
        read_reg(A_STATUS, word, resp);     // Keyboard bits stay clear
        check_read("status with aux data", word, resp, 32'h1 << STATUS_AUX_AVAIL, RESP_OKAY);
        for (int i = 0; i < 3; i++) begin
            read_reg(A_AUX, word, resp);
            check_read("aux byte in order", word, resp, VALID | 32'(sent[i]), RESP_OKAY);
        end
        print_result("aux order", mark);

        mark = errors;                      // One byte past the depth of 4
        for (int i = 0; i < 5; i++) begin
            sent[i] = 8'($urandom);
            send_frame(1'b1, sent[i], 1'b0);
        end
        read_reg(A_STATUS, word, resp);
        check_read("status after overflow", word, resp,
                   (32'h1 << STATUS_AUX_AVAIL) | (32'h1 << STATUS_AUX_OVF), RESP_OKAY);
        for (int i = 0; i < 4; i++) begin
            read_reg(A_AUX, word, resp);
            check_read("kept aux byte", word, resp, VALID | 32'(sent[i]), RESP_OKAY);
        end
        read_reg(A_AUX, word, resp);
        check_read("dropped aux byte", word, resp, 32'h0, RESP_OKAY);
        write_reg(A_CONTROL, 32'h1 << STATUS_AUX_OVF, resp);
        read_reg(A_STATUS, word, resp);
        check_read("status after overflow clear", word, resp, 32'h0, RESP_OKAY);
        print_result("overflow", mark);

        mark = errors;
        read_reg(8'h10, word, resp);
        check_read("unmapped read", word, resp, 32'h0, RESP_SLVERR);
        write_reg(A_STATUS, 32'h3F, resp);
        check_read("write to status", 32'h0, resp, 32'h0, RESP_SLVERR);
        write_reg(A_CONTROL, 32'h0, resp);
        check_read("write to control", 32'h0, resp, 32'h0, RESP_OKAY);
        print_result("bad access", mark);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== rtl/ps2_host.sv ====
// Two-port PS/2 host, keyboard and auxiliary, receive direction only
// No host-to-device commands, no interrupts, software polls STATUS
// KBD_DEPTH and AUX_DEPTH must be powers of two
`timescale 1ns/1ps

module ps2_host
    import ps2_pkg::*;
#(
    parameter int FILTER_LEN = 8,
    parameter int KBD_DEPTH  = 8,
    parameter int AUX_DEPTH  = 8
) (
    input  logic        clk,
    input  logic        reset,          // Synchronous, active low
    input  logic        kbd_clk,
    input  logic        kbd_dat,
    input  logic        aux_clk,
    input  logic        aux_dat,
    input  logic [7:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [7:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready
);

    logic [7:0] kbd_byte, aux_byte;
    logic       kbd_byte_valid, aux_byte_valid;
    logic       kbd_frame_err, aux_frame_err;
    logic       kbd_event_valid;
    key_event_t kbd_event_in, kbd_event_out;
    logic [7:0] aux_data_out;
    logic       kbd_empty, aux_empty;
    logic       kbd_pop, aux_pop;
    logic       kbd_ovf, aux_ovf;

    // ~~~~~~~~~~~~~~~~~~~~
    // Keyboard path
    // ~~~~~~~~~~~~~~~~~~~~
    ps2_rx #(.FILTER_LEN(FILTER_LEN)) i_kbd_rx (
        .clk(clk), .reset(reset), .ps2_clk(kbd_clk), .ps2_dat(kbd_dat),
        .data(kbd_byte), .byte_valid(kbd_byte_valid), .frame_error(kbd_frame_err)
    );

    ps2_key_tracker i_key_tracker (
        .clk(clk), .reset(reset), .byte_valid(kbd_byte_valid), .data(kbd_byte),
        .event_valid(kbd_event_valid), .key_event(kbd_event_in)
    );

    ps2_event_fifo #(.payload_t(key_event_t), .DEPTH(KBD_DEPTH)) i_kbd_fifo (
        .clk(clk), .reset(reset), .push(kbd_event_valid), .wdata(kbd_event_in),
        .pop(kbd_pop), .rdata(kbd_event_out), .empty(kbd_empty), .overflow(kbd_ovf)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Aux path, raw bytes
    // ~~~~~~~~~~~~~~~~~~~~
    ps2_rx #(.FILTER_LEN(FILTER_LEN)) i_aux_rx (
        .clk(clk), .reset(reset), .ps2_clk(aux_clk), .ps2_dat(aux_dat),
        .data(aux_byte), .byte_valid(aux_byte_valid), .frame_error(aux_frame_err)
    );

    ps2_event_fifo #(.payload_t(logic [7:0]), .DEPTH(AUX_DEPTH)) i_aux_fifo (
        .clk(clk), .reset(reset), .push(aux_byte_valid), .wdata(aux_byte),
        .pop(aux_pop), .rdata(aux_data_out), .empty(aux_empty), .overflow(aux_ovf)
    );

    // Register block joins both paths
    ps2_axil_regs i_regs (
        .clk(clk), .reset(reset),
        .kbd_empty(kbd_empty), .kbd_event(kbd_event_out),
        .aux_empty(aux_empty), .aux_data(aux_data_out),
        .kbd_err(kbd_frame_err), .aux_err(aux_frame_err),
        .kbd_ovf(kbd_ovf), .aux_ovf(aux_ovf),
        .kbd_pop(kbd_pop), .aux_pop(aux_pop),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
        .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
        .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready)
    );

endmodule

// ==== rtl/ps2_axil_regs.sv ====
// AXI4-Lite register block, 8-bit address, one outstanding read and write
// Data registers pop their FIFO when the read address is accepted
// Only CONTROL is writable, and only byte lane 0 carries clear bits
`timescale 1ns/1ps

module ps2_axil_regs
    import ps2_pkg::*;
(
    input  logic        clk,
    input  logic        reset,          // Synchronous, active low
    input  logic        kbd_empty,
    input  key_event_t  kbd_event,
    input  logic        aux_empty,
    input  logic [7:0]  aux_data,
    input  logic        kbd_err,        // Set pulses for the sticky flags
    input  logic        aux_err,
    input  logic        kbd_ovf,
    input  logic        aux_ovf,
    output logic        kbd_pop,
    output logic        aux_pop,
    input  logic [7:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [7:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready
);

    logic        wr_accept;   // Drives awready and wready together
    logic        wr_hs;
    logic        aw_is_ctrl;
    logic [5:0]  clr;         // W1C strobes, STATUS bit positions
    logic        rd_hs;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;
    logic        kbd_err_q, aux_err_q, kbd_ovf_q, aux_ovf_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Write channel
    // ~~~~~~~~~~~~~~~~~~~~
    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;
    assign wr_hs          = wr_accept && s_axil_awvalid && s_axil_wvalid;
    assign aw_is_ctrl     = (s_axil_awaddr == {4'h0, REG_CONTROL});
    assign clr = (wr_hs && aw_is_ctrl && s_axil_wstrb[0]) ? s_axil_wdata[5:0] : '0;

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_accept     <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            // One-cycle ready pulse, never while a response waits
            wr_accept <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !wr_accept;
            if (wr_hs)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs)
            s_axil_bresp <= aw_is_ctrl ? RESP_OKAY : RESP_SLVERR;
    end

    // Sticky flags, a set pulse beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!reset) begin
            kbd_err_q <= 1'b0;
            aux_err_q <= 1'b0;
            kbd_ovf_q <= 1'b0;
            aux_ovf_q <= 1'b0;
        end else begin
            kbd_err_q <= kbd_err || (kbd_err_q && !clr[STATUS_KBD_ERR]);
            aux_err_q <= aux_err || (aux_err_q && !clr[STATUS_AUX_ERR]);
            kbd_ovf_q <= kbd_ovf || (kbd_ovf_q && !clr[STATUS_KBD_OVF]);
            aux_ovf_q <= aux_ovf || (aux_ovf_q && !clr[STATUS_AUX_OVF]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~
    assign s_axil_arready = !s_axil_rvalid;  // One read in flight
    assign rd_hs          = s_axil_arvalid && s_axil_arready;
    assign kbd_pop = rd_hs && (s_axil_araddr == {4'h0, REG_KBD_EVENT});
    assign aux_pop = rd_hs && (s_axil_araddr == {4'h0, REG_AUX_DATA});

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (s_axil_araddr[7:4] != 4'h0) begin
            rd_resp = RESP_SLVERR;                 // Outside the window
        end else begin
            case (s_axil_araddr[3:0])
                REG_STATUS: begin
                    rd_word[STATUS_KBD_AVAIL] = !kbd_empty;
                    rd_word[STATUS_AUX_AVAIL] = !aux_empty;
                    rd_word[STATUS_KBD_ERR]   = kbd_err_q;
                    rd_word[STATUS_AUX_ERR]   = aux_err_q;
                    rd_word[STATUS_KBD_OVF]   = kbd_ovf_q;
                    rd_word[STATUS_AUX_OVF]   = aux_ovf_q;
                end
                REG_KBD_EVENT: begin
                    if (!kbd_empty) begin
                        rd_word[EVENT_VALID_BIT] = 1'b1;
                        rd_word[$bits(key_event_t)-1:0] = kbd_event;
                    end
                end
                REG_AUX_DATA: begin
                    if (!aux_empty) begin
                        rd_word[EVENT_VALID_BIT] = 1'b1;
                        rd_word[7:0] = aux_data;
                    end
                end
                REG_CONTROL: rd_word = '0;         // Clear bits read back as zero
                default:     rd_resp = RESP_SLVERR; // Misaligned offset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_hs) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    // Captured at address acceptance, held through back-pressure
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_axil_rdata <= rd_word;
            s_axil_rresp <= rd_resp;
        end
    end

    a_rdata_hold: assert property (@(posedge clk) disable iff (!reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== rtl/ps2_event_fifo.sv ====
// Small event FIFO, DEPTH must be a power of two and at least 2
// Pushes while full are dropped and reported on overflow
// rdata shows the head entry whenever empty is low
`timescale 1ns/1ps

module ps2_event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,    // Synchronous, active low
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,      // Ignored while empty
    output payload_t rdata,
    output logic     empty,
    output logic     overflow  // One-cycle pulse per dropped push
);

    localparam int AW = $clog2(DEPTH);

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           full;
    logic           do_push;
    logic           do_pop;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];

    // Pointers and occupancy, wrap is implicit with power-of-two depth
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && full;
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!reset)
        count <= (AW+1)'(DEPTH));

endmodule

// ==== rtl/ps2_key_tracker.sv ====
// Folds E0 and F0 prefix bytes into one key event
// E1 Pause sequences are not recognised and pass through as plain codes
`timescale 1ns/1ps

module ps2_key_tracker
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,       // Synchronous, active low
    input  logic       byte_valid,
    input  logic [7:0] data,
    output logic       event_valid, // One cycle after a non-prefix byte
    output key_event_t key_event
);

    localparam logic [7:0] PREFIX_EXT   = 8'hE0;
    localparam logic [7:0] PREFIX_BREAK = 8'hF0;

    logic ext_pend;  // E0 seen, waiting for the code
    logic rel_pend;  // F0 seen, waiting for the code

    // Pending flags and event strobe
    always_ff @(posedge clk) begin
        if (!reset) begin
            ext_pend    <= 1'b0;
            rel_pend    <= 1'b0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            if (byte_valid) begin
                if (data == PREFIX_EXT) begin
                    ext_pend <= 1'b1;
                end else if (data == PREFIX_BREAK) begin
                    rel_pend <= 1'b1;
                end else begin
                    event_valid <= 1'b1;
                    ext_pend    <= 1'b0; // Flags belong to this code only
                    rel_pend    <= 1'b0;
                end
            end
        end
    end

    // Event payload, only meaningful with event_valid
    always_ff @(posedge clk) begin
        if (byte_valid && data != PREFIX_EXT && data != PREFIX_BREAK) begin
            key_event.released <= rel_pend;
            key_event.extended <= ext_pend;
            key_event.code     <= data;
        end
    end

    a_prefix_silent: assert property (@(posedge clk) disable iff (!reset)
        byte_valid && (data == PREFIX_EXT || data == PREFIX_BREAK) |=> !event_valid);

endmodule

// ==== rtl/ps2_rx.sv ====
// Receive-only PS/2 framer, device-to-host direction only
// Assumes the system clock is far faster than the PS/2 clock (10-17 kHz)
// Glitches shorter than FILTER_LEN samples on the PS/2 clock are ignored
`timescale 1ns/1ps

module ps2_rx #(
    parameter int FILTER_LEN = 8
) (
    input  logic       clk,
    input  logic       reset,       // Synchronous, active low
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] data,        // Valid with byte_valid
    output logic       byte_valid,  // One-cycle pulse
    output logic       frame_error  // One-cycle pulse on bad parity or stop bit
);

    logic [1:0]            clk_meta;    // Input synchronizers
    logic [1:0]            dat_meta;
    logic [FILTER_LEN-1:0] clk_filter;
    logic                  clk_clean;
    logic                  clk_edge;
    logic [3:0]            bit_count;   // 0 idle, 1..9 data and parity, 10 stop
    logic [8:0]            shiftreg;    // Parity in bit 8 once complete
    logic                  parity_ok;

    assign data      = shiftreg[7:0];
    assign parity_ok = ^shiftreg;       // Odd parity over data plus parity bit

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock filter
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!reset) begin
            clk_meta   <= 2'b11;
            dat_meta   <= 2'b11;
            clk_filter <= '1;          // Idle lines are high
            clk_clean  <= 1'b1;
            clk_edge   <= 1'b0;
        end else begin
            clk_meta   <= {clk_meta[0], ps2_clk};
            dat_meta   <= {dat_meta[0], ps2_dat};
            clk_filter <= {clk_meta[1], clk_filter[FILTER_LEN-1:1]};
            clk_edge   <= 1'b0;

            if (&clk_filter) begin
                clk_clean <= 1'b1;
            end else if (~|clk_filter) begin
                // Only a high-to-low change counts as a bit strobe
                if (clk_clean)
                    clk_edge <= 1'b1;
                clk_clean <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Bit framing
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!reset) begin
            bit_count   <= '0;
            shiftreg    <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;

            if (clk_edge) begin
                if (bit_count == 4'd0) begin
                    if (!dat_meta[1])
                        bit_count <= 4'd1;   // Start bit
                end else if (bit_count < 4'd10) begin
                    bit_count <= bit_count + 4'd1;
                    shiftreg  <= {dat_meta[1], shiftreg[8:1]}; // LSB first
                end else begin
                    // Stop bit: parity and stop judged together
                    bit_count   <= '0;
                    byte_valid  <= parity_ok && dat_meta[1];
                    frame_error <= !(parity_ok && dat_meta[1]);
                end
            end
        end
    end

    a_no_dual_pulse: assert property (@(posedge clk) disable iff (!reset)
        !(byte_valid && frame_error));

endmodule

// ==== rtl/ps2_pkg.sv ====
// Shared types and constants for the two-port PS/2 host controller
// Register offsets are 4-bit word offsets within a small AXI4-Lite window
// The CONTROL register reuses the STATUS bit positions for its clear bits
package ps2_pkg;

    // One keyboard event after prefix folding
    typedef struct packed {
        logic       released; // F0 seen before the code
        logic       extended; // E0 seen before the code
        logic [7:0] code;     // Scan code set 2 byte
    } key_event_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] REG_STATUS    = 4'h0;
    localparam logic [3:0] REG_KBD_EVENT = 4'h4; // Pop on read
    localparam logic [3:0] REG_AUX_DATA  = 4'h8; // Pop on read
    localparam logic [3:0] REG_CONTROL   = 4'hC; // Write one to clear

    localparam int STATUS_KBD_AVAIL = 0;
    localparam int STATUS_AUX_AVAIL = 1;
    localparam int STATUS_KBD_ERR   = 2;
    localparam int STATUS_AUX_ERR   = 3;
    localparam int STATUS_KBD_OVF   = 4;
    localparam int STATUS_AUX_OVF   = 5;

    localparam int EVENT_VALID_BIT  = 31; // Set when a data read returns a real entry

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
